/* Makefile */
# Verilator build and run of the VGA sync checker testbench

VERILATOR ?= verilator
TOP       ?= vga_top_tb
SEED      ?= 32'hE112B92C
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP SEED LOG OBJ_DIR FILELIST VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) "-GSEED=$(SEED)" \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	@$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "FAILED, see $(LOG)"; exit 1; \
	fi; \
	echo "PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/vga_check_status.sv */
`timescale 1ns/1ns

module vga_check_status (
   input  logic               clk,
   input  logic               rst,
   input  vga_pkg::sync_err_t err,
   input  logic               frame_done,
   output vga_pkg::sync_err_t err_flags,
   output logic [15:0]        frames,
   output logic               locked
);

   // Sticky flags, only reset clears them
   always_ff @(posedge clk) begin
      if (rst) begin
         err_flags <= '0;
      end else begin
         err_flags <= err_flags | err;
      end
   end

   // Checked frames, holds at full scale
   always_ff @(posedge clk) begin
      if (rst) begin
         frames <= '0;
      end else if (frame_done && frames != 16'hffff) begin
         frames <= frames + 16'd1;
      end
   end

   // Set by the first checked frame
   always_ff @(posedge clk) begin
      if (rst) begin
         locked <= 1'b0;
      end else if (frame_done) begin
         locked <= 1'b1;
      end
   end

endmodule

/* hw/vga_pattern_gen.sv */
`timescale 1ns/1ns

module vga_pattern_gen (
   input  logic              clk,
   input  logic              rst,
   input  vga_pkg::pix_pos_t pos,
   input  logic              hsync,
   input  logic              vsync,
   output vga_pkg::vga_bus_t vga_out
);
   import vga_pkg::*;

   // Full drive level for a lit channel
   localparam colour_t FULL = 4'hf;

   logic [2:0] bar_idx;
   logic [2:0] bar_rgb;
   colour_t    r_next;
   colour_t    g_next;
   colour_t    b_next;

   // Classic bar order, {r, g, b}
   // white yellow cyan green magenta red blue black
   function automatic logic [2:0] bar_colour(input logic [2:0] idx);
      case (idx)
         3'd0:    return 3'b111;
         3'd1:    return 3'b110;
         3'd2:    return 3'b011;
         3'd3:    return 3'b010;
         3'd4:    return 3'b101;
         3'd5:    return 3'b100;
         3'd6:    return 3'b001;
         default: return 3'b000;
      endcase
   endfunction

   // Bars two pixels wide, repeating every 16 pixels
   // Order shifts by one per line, 3-bit add wraps on purpose
   assign bar_idx = pos.x[3:1] + pos.y[2:0];
   assign bar_rgb = bar_colour(bar_idx);

   // Blanking forces black
   assign r_next = (pos.active && bar_rgb[2]) ? FULL : '0;
   assign g_next = (pos.active && bar_rgb[1]) ? FULL : '0;
   assign b_next = (pos.active && bar_rgb[0]) ? FULL : '0;

   // Colour and syncs share one stage so they stay aligned
   always_ff @(posedge clk) begin
      if (rst) begin
         vga_out <= '{r: '0, g: '0, b: '0, hsync: 1'b1, vsync: 1'b1};
      end else begin
         vga_out.r     <= r_next;
         vga_out.g     <= g_next;
         vga_out.b     <= b_next;
         vga_out.hsync <= hsync;
         vga_out.vsync <= vsync;
      end
   end

endmodule

/* hw/vga_pkg.sv */
package vga_pkg;

   // Counter width shared by generator and checker
   // 12 bits covers 800 clocks per line and 525 lines per frame
   localparam int CNT_W = 12;

   // One colour channel
   // 4 bits per DAC on the board
   typedef logic [3:0] colour_t;

   // Pixel bus as it appears on the connector
   // Syncs active low, idle high
   typedef struct packed {
      colour_t r;
      colour_t g;
      colour_t b;
      logic    hsync;
      logic    vsync;
   } vga_bus_t;

   // Raster position from the timing generator
   typedef struct packed {
      // Pixel within the line, 0 at first visible pixel
      logic [11:0] x;
      // Line within the frame, 0 at first visible line
      logic [10:0] y;
      // Inside the visible window
      logic        active;
   } pix_pos_t;

   // Checker error flags
   // One bit per rule, strobed or sticky depending on the owner
   typedef struct packed {
      // hsync low width
      logic hpw;
      // Line period, fall to fall
      logic hper;
      // vsync low width in lines
      logic vpw;
      // Frame period in lines
      logic vper;
      // Colour seen outside the active window
      logic blank;
   } sync_err_t;

endpackage

/* hw/vga_sync_checker.sv */
`timescale 1ns/1ns

module vga_sync_checker #(
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_PW     = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_PW     = 2,
   parameter int V_BP     = 33
) (
   input  logic               clk,
   input  logic               rst,
   input  vga_pkg::vga_bus_t  vga_in,
   output vga_pkg::sync_err_t err,
   output logic               frame_done
);
   import vga_pkg::*;

   localparam int H_TOTAL = H_ACTIVE + H_FP + H_PW + H_BP;
   localparam int V_TOTAL = V_ACTIVE + V_FP + V_PW + V_BP;

   // Expected measurements
   localparam logic [CNT_W-1:0] EXP_HPW  = CNT_W'(H_PW);
   localparam logic [CNT_W-1:0] EXP_HPER = CNT_W'(H_TOTAL);
   localparam logic [CNT_W-1:0] EXP_VPW  = CNT_W'(V_PW);
   localparam logic [CNT_W-1:0] EXP_VPER = CNT_W'(V_TOTAL);

   // Window seen from the sync falls, sync pulse and back porch come first
   localparam logic [CNT_W-1:0] H_WIN_LO = CNT_W'(H_PW + H_BP);
   localparam logic [CNT_W-1:0] H_WIN_HI = CNT_W'(H_PW + H_BP + H_ACTIVE);
   localparam logic [CNT_W-1:0] V_WIN_LO = CNT_W'(V_PW + V_BP);
   localparam logic [CNT_W-1:0] V_WIN_HI = CNT_W'(V_PW + V_BP + V_ACTIVE);
   localparam logic [CNT_W-1:0] H_LAST   = CNT_W'(H_TOTAL - 1);
   localparam logic [CNT_W-1:0] V_LAST   = CNT_W'(V_TOTAL - 1);
   // Pixel just before a line start, where vsync may change
   localparam logic [CNT_W-1:0] H_PRE_LS = CNT_W'((H_PW + H_BP + H_TOTAL - 1) % H_TOTAL);

   logic             hs_q;
   logic             vs_q;
   logic             hs_fall;
   logic             hs_rise;
   logic             vs_fall;
   logic             vs_rise;
   logic             armed;
   logic             h_seen;
   logic [CNT_W-1:0] h_low_cnt;
   logic [CNT_W-1:0] h_per_cnt;
   logic [CNT_W-1:0] v_low_cnt;
   logic [CNT_W-1:0] v_per_cnt;
   logic [CNT_W-1:0] h_pos;
   logic [CNT_W-1:0] v_pos;
   logic [CNT_W-1:0] hx;
   logic [CNT_W-1:0] vy;
   logic             in_window;
   logic             colour_on;
   sync_err_t        err_next;

   // Previous sync levels, idle high
   always_ff @(posedge clk) begin
      if (rst) begin
         hs_q <= 1'b1;
         vs_q <= 1'b1;
      end else begin
         hs_q <= vga_in.hsync;
         vs_q <= vga_in.vsync;
      end
   end

   assign hs_fall = hs_q && !vga_in.hsync;
   assign hs_rise = !hs_q && vga_in.hsync;
   assign vs_fall = vs_q && !vga_in.vsync;
   assign vs_rise = !vs_q && vga_in.vsync;

   // First vsync fall arms, line checks wait for a fall while armed
   always_ff @(posedge clk) begin
      if (rst) begin
         armed  <= 1'b0;
         h_seen <= 1'b0;
      end else begin
         if (vs_fall) armed <= 1'b1;
         if (hs_fall && (armed || vs_fall)) h_seen <= 1'b1;
      end
   end

   // Width and period in clocks, edge cycle counts as one
   // Saturate so a stuck sync cannot wrap back to a legal value
   always_ff @(posedge clk) begin
      if (rst) begin
         h_low_cnt <= '0;
         h_per_cnt <= '0;
      end else if (hs_fall) begin
         h_low_cnt <= CNT_W'(1);
         h_per_cnt <= CNT_W'(1);
      end else begin
         if (!vga_in.hsync && h_low_cnt != '1) h_low_cnt <= h_low_cnt + 1'b1;
         if (h_per_cnt != '1) h_per_cnt <= h_per_cnt + 1'b1;
      end
   end

   // Width and period in lines, one hsync fall per line
   always_ff @(posedge clk) begin
      if (rst) begin
         v_low_cnt <= '0;
         v_per_cnt <= '0;
      end else if (vs_fall) begin
         v_low_cnt <= hs_fall ? CNT_W'(1) : '0;
         v_per_cnt <= hs_fall ? CNT_W'(1) : '0;
      end else if (hs_fall) begin
         // Fall on the rising vsync edge belongs to the next line
         if (!vga_in.vsync && v_low_cnt != '1) v_low_cnt <= v_low_cnt + 1'b1;
         if (v_per_cnt != '1) v_per_cnt <= v_per_cnt + 1'b1;
      end
   end

   // Flywheel position, pulled back to zero by each fall
   assign hx = hs_fall ? '0 : h_pos;
   assign vy = vs_fall ? '0 : v_pos;

   always_ff @(posedge clk) begin
      if (rst) begin
         h_pos <= '0;
         v_pos <= '0;
      end else begin
         h_pos <= (hx == H_LAST) ? '0 : hx + 1'b1;
         if (hx == H_PRE_LS) begin
            v_pos <= (vy == V_LAST) ? '0 : vy + 1'b1;
         end else begin
            v_pos <= vy;
         end
      end
   end

   assign in_window = (hx >= H_WIN_LO) && (hx < H_WIN_HI) &&
                      (vy >= V_WIN_LO) && (vy < V_WIN_HI);
   assign colour_on = |{vga_in.r, vga_in.g, vga_in.b};

   // Widths close on the rising edge, periods on the next fall
   always_comb begin
      err_next       = '0;
      err_next.hpw   = h_seen && hs_rise && (h_low_cnt != EXP_HPW);
      err_next.hper  = h_seen && hs_fall && (h_per_cnt != EXP_HPER);
      err_next.vpw   = armed && vs_rise && (v_low_cnt != EXP_VPW);
      err_next.vper  = armed && vs_fall && (v_per_cnt != EXP_VPER);
      err_next.blank = armed && !in_window && colour_on;
   end

   // Strobes one clock after the closing edge
   always_ff @(posedge clk) begin
      if (rst) begin
         err        <= '0;
         frame_done <= 1'b0;
      end else begin
         err        <= err_next;
         frame_done <= vs_fall && armed;
      end
   end

endmodule

/* hw/vga_timing_gen.sv */
`timescale 1ns/1ns

module vga_timing_gen #(
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_PW     = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_PW     = 2,
   parameter int V_BP     = 33
) (
   input  logic              clk,
   input  logic              rst,
   output vga_pkg::pix_pos_t pos,
   output logic              hsync,
   output logic              vsync
);
   import vga_pkg::*;

   // Totals in clocks and in lines
   localparam int H_TOTAL = H_ACTIVE + H_FP + H_PW + H_BP;
   localparam int V_TOTAL = V_ACTIVE + V_FP + V_PW + V_BP;

   // Wrap points
   localparam logic [CNT_W-1:0] H_LAST = CNT_W'(H_TOTAL - 1);
   localparam logic [CNT_W-1:0] V_LAST = CNT_W'(V_TOTAL - 1);

   // Visible area starts at counter zero
   localparam logic [CNT_W-1:0] H_VIS = CNT_W'(H_ACTIVE);
   localparam logic [CNT_W-1:0] V_VIS = CNT_W'(V_ACTIVE);

   // Sync pulse placed after the front porch
   localparam logic [CNT_W-1:0] HS_START = CNT_W'(H_ACTIVE + H_FP);
   localparam logic [CNT_W-1:0] HS_END   = CNT_W'(H_ACTIVE + H_FP + H_PW);
   localparam logic [CNT_W-1:0] VS_START = CNT_W'(V_ACTIVE + V_FP);
   localparam logic [CNT_W-1:0] VS_END   = CNT_W'(V_ACTIVE + V_FP + V_PW);

   logic [CNT_W-1:0] h_cnt;
   logic [CNT_W-1:0] v_cnt;
   logic             line_end;

   assign line_end = (h_cnt == H_LAST);

   // Pixel counter, one step per clock
   always_ff @(posedge clk) begin
      if (rst) begin
         h_cnt <= '0;
      end else if (line_end) begin
         h_cnt <= '0;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // Line counter, steps on the last pixel of each line
   // so vsync changes exactly at a line start
   always_ff @(posedge clk) begin
      if (rst) begin
         v_cnt <= '0;
      end else if (line_end) begin
         if (v_cnt == V_LAST) begin
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + 1'b1;
         end
      end
   end

   assign pos.x      = h_cnt;
   // Upper bit never set for legal frame sizes
   assign pos.y      = v_cnt[10:0];
   assign pos.active = (h_cnt < H_VIS) && (v_cnt < V_VIS);

   // Active low pulses
   assign hsync = !((h_cnt >= HS_START) && (h_cnt < HS_END));
   assign vsync = !((v_cnt >= VS_START) && (v_cnt < VS_END));

endmodule

/* hw/vga_top.sv */
`timescale 1ns/1ns

module vga_top #(
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_PW     = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_PW     = 2,
   parameter int V_BP     = 33
) (
   input  logic               clk,
   input  logic               rst,
   output vga_pkg::vga_bus_t  vga_out,
   input  vga_pkg::vga_bus_t  vga_in,
   output vga_pkg::sync_err_t err_flags,
   output logic [15:0]        frames,
   output logic               locked
);

   // Raster position and raw syncs, one clock ahead of vga_out
   vga_pkg::pix_pos_t  pos;
   logic               hsync;
   logic               vsync;

   // Checker strobes
   vga_pkg::sync_err_t err;
   logic               frame_done;

   vga_timing_gen #(
      .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) u_timing (
      .clk   (clk),
      .rst   (rst),
      .pos   (pos),
      .hsync (hsync),
      .vsync (vsync)
   );

   vga_pattern_gen u_pattern (
      .clk     (clk),
      .rst     (rst),
      .pos     (pos),
      .hsync   (hsync),
      .vsync   (vsync),
      .vga_out (vga_out)
   );

   // Watches the external input, not vga_out
   vga_sync_checker #(
      .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) u_checker (
      .clk        (clk),
      .rst        (rst),
      .vga_in     (vga_in),
      .err        (err),
      .frame_done (frame_done)
   );

   vga_check_status u_status (
      .clk        (clk),
      .rst        (rst),
      .err        (err),
      .frame_done (frame_done),
      .err_flags  (err_flags),
      .frames     (frames),
      .locked     (locked)
   );

endmodule

/* sim.f */
hw/vga_pkg.sv
hw/vga_timing_gen.sv
hw/vga_pattern_gen.sv
hw/vga_sync_checker.sv
hw/vga_check_status.sv
hw/vga_top.sv
tb/vga_top_asserts.sv
tb/vga_top_tb.sv

/* tb/vga_top_asserts.sv */
`timescale 1ns/1ns

module vga_top_asserts #(
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_PW     = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_PW     = 2,
   parameter int V_BP     = 33
) (
   input logic              clk,
   input logic              rst,
   input vga_pkg::vga_bus_t vga_out
);
   import vga_pkg::*;

   localparam int H_TOTAL = H_ACTIVE + H_FP + H_PW + H_BP;
   localparam int V_TOTAL = V_ACTIVE + V_FP + V_PW + V_BP;
   // First visible pixel and line as seen from the sync falls
   localparam int X_FIRST = H_PW + H_BP;
   localparam int Y_FIRST = V_PW + V_BP;

   // Read by the testbench at the end of the run
   int   failures = 0;
   logic hs_q;
   logic vs_q;
   logic hs_fall;
   logic hs_rise;
   logic vs_fall;
   logic vs_rise;
   logic h_seen;
   logic v_seen;
   int   h_low;
   int   h_per;
   int   v_low;
   int   v_per;
   int   hx_q;
   int   vy_q;
   int   hx;
   int   vy;
   logic new_line;
   logic blanking;

   assign hs_fall = hs_q && !vga_out.hsync;
   assign hs_rise = !hs_q && vga_out.hsync;
   assign vs_fall = vs_q && !vga_out.vsync;
   assign vs_rise = !vs_q && vga_out.vsync;

   // Position in the current cycle
   assign hx       = hs_fall ? 0 : hx_q;
   assign new_line = (hx == X_FIRST);
   assign vy       = vs_fall ? 0 : (new_line ? vy_q + 1 : vy_q);
   assign blanking = !((hx >= X_FIRST) && (hx < X_FIRST + H_ACTIVE) &&
                       (vy >= Y_FIRST) && (vy < Y_FIRST + V_ACTIVE));

   // Counts up to the cycle before the one being checked
   always_ff @(posedge clk) begin
      if (rst) begin
         hs_q   <= 1'b1;
         vs_q   <= 1'b1;
         h_seen <= 1'b0;
         v_seen <= 1'b0;
         h_low  <= 0;
         h_per  <= 0;
         v_low  <= 0;
         v_per  <= 0;
         hx_q   <= 0;
         vy_q   <= 0;
      end else begin
         hs_q   <= vga_out.hsync;
         vs_q   <= vga_out.vsync;
         h_seen <= h_seen || hs_fall;
         v_seen <= v_seen || vs_fall;
         h_low  <= hs_fall ? 1 : (vga_out.hsync ? h_low : h_low + 1);
         h_per  <= hs_fall ? 1 : h_per + 1;
         // Vertical widths in clocks, lines times line length
         v_low  <= vs_fall ? 1 : (vga_out.vsync ? v_low : v_low + 1);
         v_per  <= vs_fall ? 1 : v_per + 1;
         hx_q   <= hx + 1;
         vy_q   <= vy;
      end
   end

   hsync_width: assert property (@(posedge clk) disable iff (rst)
      (h_seen && hs_rise) |-> (h_low == H_PW))
      else begin
         $error("hsync low pulse has the wrong width");
         failures++;
      end

   vsync_width: assert property (@(posedge clk) disable iff (rst)
      (v_seen && vs_rise) |-> (v_low == V_PW * H_TOTAL))
      else begin
         $error("vsync low pulse has the wrong width");
         failures++;
      end

   // Fall to fall
   line_period: assert property (@(posedge clk) disable iff (rst)
      (h_seen && hs_fall) |-> (h_per == H_TOTAL))
      else begin
         $error("hsync falls are not one line apart");
         failures++;
      end

   frame_period: assert property (@(posedge clk) disable iff (rst)
      (v_seen && vs_fall) |-> (v_per == V_TOTAL * H_TOTAL))
      else begin
         $error("vsync falls are not one frame apart");
         failures++;
      end

   // Black outside the window
   blank_colour: assert property (@(posedge clk) disable iff (rst)
      (h_seen && v_seen && blanking) |->
         (vga_out.r == '0 && vga_out.g == '0 && vga_out.b == '0))
      else begin
         $error("colour is not zero during blanking");
         failures++;
      end

endmodule

/* tb/vga_top_tb.sv */
`timescale 1ns/1ns

module vga_top_tb #(
   parameter logic [31:0] SEED = 32'he112_b92c
);
   import vga_pkg::*;

   // Small frame of 24 clocks by 11 lines
   localparam int H_ACTIVE     = 16;
   localparam int H_FP         = 2;
   localparam int H_PW         = 3;
   localparam int H_BP         = 3;
   localparam int V_ACTIVE     = 6;
   localparam int V_FP         = 1;
   localparam int V_PW         = 2;
   localparam int V_BP         = 2;
   localparam int FRAME_CLKS   = (H_ACTIVE + H_FP + H_PW + H_BP) *
                                 (V_ACTIVE + V_FP + V_PW + V_BP);
   localparam int RESET_CYCLES = 16;
   // One reset per test group
   localparam int CYCLE_LIMIT  = 12 * FRAME_CLKS + 4 * RESET_CYCLES;

   logic        clk = 1'b0;
   logic        rst;
   vga_bus_t    vga_in;
   vga_bus_t    vga_out;
   sync_err_t   err_flags;
   logic [15:0] frames;
   logic        locked;

   int        seed;
   int        cycles;
   int        pass_count;
   int        fail_count;
   int        offset;
   sync_err_t want;
   // Output sync edges in the current cycle
   logic      hs_prev;
   logic      vs_prev;
   logic      out_hs_fall;
   logic      out_hs_rise;
   logic      out_vs_fall;
   logic      out_vs_rise;

   vga_top #(
      .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) DUT (
      .clk       (clk),
      .rst       (rst),
      .vga_out   (vga_out),
      .vga_in    (vga_in),
      .err_flags (err_flags),
      .frames    (frames),
      .locked    (locked)
   );

   bind vga_top vga_top_asserts #(
      .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) u_asserts (
      .clk     (clk),
      .rst     (rst),
      .vga_out (vga_out)
   );

   initial begin
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run timed out after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // Loopback copy that a test may corrupt after it returns
   task automatic next_cycle();
      @(negedge clk);
      out_hs_fall = hs_prev && !vga_out.hsync;
      out_hs_rise = !hs_prev && vga_out.hsync;
      out_vs_fall = vs_prev && !vga_out.vsync;
      out_vs_rise = !vs_prev && vga_out.vsync;
      hs_prev     = vga_out.hsync;
      vs_prev     = vga_out.vsync;
      vga_in      = vga_out;
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (RESET_CYCLES) next_cycle();
      rst = 1'b0;
   endtask

   task automatic wait_hsync_fall();
      do begin
         next_cycle();
      end while (!out_hs_fall);
   endtask

   task automatic wait_hsync_rise();
      do begin
         next_cycle();
      end while (!out_hs_rise);
   endtask

   task automatic wait_vsync_fall();
      do begin
         next_cycle();
      end while (!out_vs_fall);
   endtask

   task automatic wait_lines(input int n);
      repeat (n) wait_hsync_fall();
   endtask

   task automatic report_check(input string name, input bit ok,
                               input string expected, input string actual);
      assert (ok) begin
         pass_count++;
         $display("[PASS] %s", name);
      end else begin
         fail_count++;
         $display("[FAIL] %s expected %s actual %s", name, expected, actual);
      end
   endtask

   initial begin
      seed        = SEED;
      cycles      = 0;
      pass_count  = 0;
      fail_count  = 0;
      rst         = 1'b1;
      vga_in      = '{r: '0, g: '0, b: '0, hsync: 1'b1, vsync: 1'b1};
      hs_prev     = 1'b1;
      vs_prev     = 1'b1;
      out_hs_fall = 1'b0;
      out_hs_rise = 1'b0;
      out_vs_fall = 1'b0;
      out_vs_rise = 1'b0;

      // Clean loopback where the first vsync fall only arms
      apply_reset();
      repeat (4) wait_vsync_fall();
      wait_lines(2);
      report_check("clean_err_flags", err_flags == '0, "00000",
                   $sformatf("%05b", err_flags));
      report_check("clean_locked", locked == 1'b1, "1", $sformatf("%0b", locked));
      report_check("clean_frames", frames >= 16'd3, "at least 3",
                   $sformatf("%0d", frames));

      // One extra low clock on the first hsync pulse after arming
      apply_reset();
      wait_vsync_fall();
      wait_hsync_rise();
      vga_in.hsync = 1'b0;
      wait_lines(2);
      want     = '0;
      want.hpw = 1'b1;
      report_check("hsync_stretch", err_flags == want, $sformatf("%05b", want),
                   $sformatf("%05b", err_flags));

      // Sync and back porch are blank on every line
      apply_reset();
      wait_vsync_fall();
      offset = $unsigned($random(seed)) % (H_PW + H_BP);
      wait_hsync_fall();
      repeat (offset) next_cycle();
      vga_in.g = 4'h9;
      wait_lines(2);
      want       = '0;
      want.blank = 1'b1;
      report_check("blank_pixel", err_flags == want, $sformatf("%05b", want),
                   $sformatf("%05b", err_flags));

      // Hide the second vsync pulse so the next period spans two frames
      apply_reset();
      wait_vsync_fall();
      wait_vsync_fall();
      do begin
         vga_in.vsync = 1'b1;
         next_cycle();
      end while (!out_vs_rise);
      wait_vsync_fall();
      wait_lines(2);
      want      = '0;
      want.vper = 1'b1;
      report_check("vsync_removed", err_flags == want, $sformatf("%05b", want),
                   $sformatf("%05b", err_flags));

      report_check("stream_assertions", DUT.u_asserts.failures == 0, "0",
                   $sformatf("%0d", DUT.u_asserts.failures));

      $display("Tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
